//--- testbench/lsuBusTests.txt
# kind adr funct3 data0 data1 data2 data3 cpuBusy exp0 exp1 exp2 exp3 (all hex)
# kind 0 uncached load, 1 uncached store, 2 line fetch, 3 line writeback, 4 ignored load
0 00001000 2 0 0 0 0 0 C0DE1000 0 0 0
1 00001004 2 DEADBEEF 0 0 0 0 DEADBEEF 0 0 0
0 00001004 2 0 0 0 0 0 DEADBEEF 0 0 0
0 00002010 0 0 0 0 0 0 C0DE2010 0 0 0
2 00003000 2 0 0 0 0 0 C0DE3000 C0DE3004 C0DE3008 C0DE300C
3 00004000 2 11111111 22222222 33333333 44444444 0 11111111 22222222 33333333 44444444
2 00004000 2 0 0 0 0 0 11111111 22222222 33333333 44444444
0 00005000 2 0 0 0 0 1 C0DE5000 0 0 0
4 00006000 2 0 0 0 0 0 0 0 0 0
1 00001000 0 000000AB 0 0 0 0 000000AB 0 0 0
0 00001000 0 0 0 0 0 0 000000AB 0 0 0
2 00001000 2 0 0 0 0 0 000000AB DEADBEEF C0DE1008 C0DE100C
1 00005008 1 0000CAFE 0 0 0 1 0000CAFE 0 0 0
0 00005008 2 0 0 0 0 0 0000CAFE 0 0 0

//--- build.f
verilog/lsuBusPkg.sv
verilog/busFsm.sv
verilog/busDataPath.sv
verilog/lsuBus.sv
testbench/tbLsuBus.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tbLsuBus -f build.f -o simLsuBus
./obj_dir/simLsuBus > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
  exit 1
fi
grep -q "Simulation passed" sim.log

//--- testbench/tbLsuBus.sv
`default_nettype none

module tbLsuBus;
  timeunit 1ns;
  timeprecision 1ps;
  import lsuBusPkg::*;

  localparam int WordsPerLine = 4;
  localparam int LogWpl = 2;
  localparam int LineLen = WordsPerLine * XLEN;
  localparam int MaxTests = 32;
  // Untouched memory words read back as their address mixed with this pattern
  localparam busWordT MemSeed = 32'hC0DE_0000;

  logic               clk;
  logic               reset;
  lsuReqT             lsuReq;
  logic               ignoreRequest;
  logic               cpuBusy;
  cacheReqT           cacheReq;
  logic [LineLen-1:0] cacheLine;
  logic               busAck = 1'b0;
  busWordT            busReadData = '0;
  logic               busStall;
  logic               busCommitted;
  logic               cacheBusAck;
  logic [LineLen-1:0] lineBuffer;
  logic               selUncachedAdr;
  logic               busRead;
  logic               busWrite;
  physAdrT            busAdr;
  logic [2:0]         busSize;
  busWordT            busWriteData;
  logic [LogWpl-1:0]  wordCount;

  // Test table as read from the data file
  int         tKind [MaxTests];
  physAdrT    tAdr [MaxTests];
  logic [2:0] tFunct3 [MaxTests];
  logic       tBusy [MaxTests];
  busWordT    tData [MaxTests][WordsPerLine];
  busWordT    tExp [MaxTests][WordsPerLine];
  int         numTests = 0;

  // Shadow memory and the words the monitor saw complete
  busWordT    mem [physAdrT];
  physAdrT    xferAdr [$];
  busWordT    xferData [$];
  logic [2:0] xferSize [$];
  logic       xferSel [$];
  int         lineAcks = 0;
  int         strobeCycles = 0;
  int         waitLeft = 0;
  int         cycles = 0;
  int         limit = 0;
  int         errors = 0;
  int         passCount = 0;
  int         failCount = 0;

  lsuBus #(
    .WordsPerLine(WordsPerLine),
    .LogWpl(LogWpl)
  ) u_lsuBus (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Memory model
  //////////////////////////////

  function automatic busWordT readMem(physAdrT adr);
    physAdrT wordAdr;
    wordAdr = {adr[PA_BITS-1:2], 2'b00};
    if (mem.exists(wordAdr)) begin
      return mem[wordAdr];
    end else begin
      return wordAdr ^ MemSeed;
    end
  endfunction

  // Acknowledge after a random wait of 0 to 3 cycles with one word per acknowledge
  always @(posedge clk) begin
    if (reset || busAck) begin
      busAck <= 1'b0;
      waitLeft <= $urandom % 4;
    end else if ((busRead || busWrite) && waitLeft == 0) begin
      busAck <= 1'b1;
      busReadData <= readMem(busAdr);
    end else if (busRead || busWrite) begin
      waitLeft <= waitLeft - 1;
    end
  end

  // Records each completed word
  // Stores also land in the shadow memory
  always @(posedge clk) begin
    if (!reset) begin
      if (busRead || busWrite)
        strobeCycles++;
      if (cacheBusAck)
        lineAcks++;
      if (busAck && (busRead || busWrite)) begin
        xferAdr.push_back(busAdr);
        xferSize.push_back(busSize);
        xferSel.push_back(selUncachedAdr);
        xferData.push_back(busRead ? busReadData : busWriteData);
        if (busWrite)
          mem[{busAdr[PA_BITS-1:2], 2'b00}] = busWriteData;
      end
    end
  end

  // The run length guard is armed once the table size is known
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout after %0d cycles without finishing the tests", limit);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reportMismatch(string name, busWordT expected, busWordT actual);
    $display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic loadTests();
    int    fd;
    string line;
    fd = $fopen("testbench/lsuBusTests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test file testbench/lsuBusTests.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Comment lines start with a hash and blank lines are skipped
        if (line.len() > 1 && line[0] != "#" && numTests < MaxTests) begin
          if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
              tKind[numTests], tAdr[numTests], tFunct3[numTests],
              tData[numTests][0], tData[numTests][1], tData[numTests][2],
              tData[numTests][3], tBusy[numTests], tExp[numTests][0],
              tExp[numTests][1], tExp[numTests][2], tExp[numTests][3]) == 12) begin
            numTests++;
          end else begin
            $display("Test file line could not be read: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
      if (numTests == 0) begin
        $display("No tests were read from the test file");
        errors++;
      end
    end
  endtask

  task automatic runTest(int i);
    int      errorsBefore;
    physAdrT expAdr;
    errorsBefore = errors;
    xferAdr.delete();
    xferData.delete();
    xferSize.delete();
    xferSel.delete();
    lineAcks = 0;
    strobeCycles = 0;
    @(posedge clk);
    if (tKind[i] == 2 || tKind[i] == 3) begin
      // Line fetch or writeback request is held as a level until cacheBusAck
      cacheLine <= {tData[i][3], tData[i][2], tData[i][1], tData[i][0]};
      cacheReq <= '{lineAdr: tAdr[i], fetchLine: tKind[i] == 2, writeLine: tKind[i] == 3};
      @(negedge clk);
      while (cacheBusAck !== 1'b1)
        @(negedge clk);
      @(posedge clk);
      cacheReq.fetchLine <= 1'b0;
      cacheReq.writeLine <= 1'b0;
      @(negedge clk);
      if (lineAcks != 1) begin
        $display("cacheBusAck pulsed %0d times instead of once", lineAcks);
        errors++;
      end
      // The count is back at the first word once the line is done
      if (wordCount !== '0)
        reportMismatch("wordCount", 32'd0, 32'(wordCount));
      if (xferAdr.size() != WordsPerLine) begin
        $display("Line transfer moved %0d words instead of %0d", xferAdr.size(), WordsPerLine);
        errors++;
      end else begin
        for (int w = 0; w < WordsPerLine; w++) begin
          expAdr = tAdr[i] + physAdrT'(4 * w);
          if (xferAdr[w] !== expAdr)
            reportMismatch("busAdr", expAdr, xferAdr[w]);
          // Line words always move at full word size
          if (xferSize[w] !== 3'd2)
            reportMismatch("busSize", 32'd2, 32'(xferSize[w]));
          if (xferSel[w] !== 1'b0)
            reportMismatch("selUncachedAdr", 32'd0, 32'(xferSel[w]));
          if (xferData[w] !== tExp[i][w])
            reportMismatch(tKind[i] == 2 ? "busReadData" : "busWriteData", tExp[i][w], xferData[w]);
          if (tKind[i] == 2 && lineBuffer[w*XLEN +: XLEN] !== tExp[i][w])
            reportMismatch("lineBuffer", tExp[i][w], lineBuffer[w*XLEN +: XLEN]);
        end
      end
    end else begin
      lsuReq <= '{adr: tAdr[i], rw: (tKind[i] == 1) ? 2'b01 : 2'b10, funct3: tFunct3[i],
                  cacheable: 1'b0, writeData: tData[i][0]};
      ignoreRequest <= (tKind[i] == 4);
      cpuBusy <= tBusy[i];
      @(negedge clk);
      if (tKind[i] == 4) begin
        repeat (4) @(negedge clk);
        if (strobeCycles != 0 || busStall !== 1'b0) begin
          $display("Bus strobe or stall rose although the request was ignored");
          errors++;
        end
        @(posedge clk);
        lsuReq.rw <= 2'b00;
        ignoreRequest <= 1'b0;
      end else begin
        // Stall starts in the cycle the request appears
        if (busStall !== 1'b1)
          reportMismatch("busStall", 32'd1, 32'(busStall));
        while (!(busAck && (busRead || busWrite)))
          @(negedge clk);
        @(posedge clk);
        // A busy pipeline keeps its request up and the FSM must not repeat the access
        if (!tBusy[i])
          lsuReq.rw <= 2'b00;
        @(negedge clk);
        if (busStall !== 1'b0)
          reportMismatch("busStall", 32'd0, 32'(busStall));
        if (tBusy[i]) begin
          repeat (3) begin
            if (busCommitted !== 1'b1)
              reportMismatch("busCommitted", 32'd1, 32'(busCommitted));
            @(negedge clk);
          end
          @(posedge clk);
          cpuBusy <= 1'b0;
          lsuReq.rw <= 2'b00;
          repeat (2) @(negedge clk);
          if (busCommitted !== 1'b0)
            reportMismatch("busCommitted", 32'd0, 32'(busCommitted));
        end
        if (xferAdr.size() != 1) begin
          $display("Uncached access moved %0d words instead of one", xferAdr.size());
          errors++;
        end else begin
          if (xferAdr[0] !== tAdr[i])
            reportMismatch("busAdr", tAdr[i], xferAdr[0]);
          if (xferSize[0] !== tFunct3[i])
            reportMismatch("busSize", 32'(tFunct3[i]), 32'(xferSize[0]));
          if (xferSel[0] !== 1'b1)
            reportMismatch("selUncachedAdr", 32'd1, 32'(xferSel[0]));
          if (xferData[0] !== tExp[i][0])
            reportMismatch(tKind[i] == 0 ? "busReadData" : "busWriteData", tExp[i][0], xferData[0]);
        end
      end
    end
    if (errors == errorsBefore) begin
      passCount++;
    end else begin
      failCount++;
    end
    $display("Test %0d kind %0d adr %h %s", i, tKind[i], tAdr[i],
             (errors == errorsBefore) ? "ok" : "failed");
  endtask

  initial begin
    void'($urandom(31));
    reset = 1'b1;
    lsuReq = '0;
    ignoreRequest = 1'b0;
    cpuBusy = 1'b0;
    cacheReq = '0;
    cacheLine = '0;
    loadTests();
    limit = numTests * 40;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    // Bus idle and nothing committed before the first request
    if ({busRead, busWrite, busStall, busCommitted, cacheBusAck} !== 5'b0)
      reportMismatch("busRead busWrite busStall busCommitted cacheBusAck", 32'd0,
                     32'({busRead, busWrite, busStall, busCommitted, cacheBusAck}));
    if (wordCount !== '0)
      reportMismatch("wordCount", 32'd0, 32'(wordCount));
    for (int i = 0; i < numTests; i++)
      runTest(i);
    $display("Tests passed %0d failed %0d errors %0d", passCount, failCount, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/lsuBus.sv
`default_nettype none

module lsuBus #(
  parameter int WordsPerLine = 4,
  parameter int LogWpl = 2,
  localparam int LineLen = WordsPerLine * lsuBusPkg::XLEN
) (
  input  logic                clk,
  input  logic                reset,
  // Load/store stage
  input  lsuBusPkg::lsuReqT   lsuReq,
  input  logic                ignoreRequest,
  input  logic                cpuBusy,
  output logic                busStall,
  output logic                busCommitted,
  // Data cache
  input  lsuBusPkg::cacheReqT cacheReq,
  input  logic [LineLen-1:0]  cacheLine,
  output logic                cacheBusAck,
  output logic [LineLen-1:0]  lineBuffer,
  output logic                selUncachedAdr,
  // Word-wide memory bus
  output logic                busRead,
  output logic                busWrite,
  output lsuBusPkg::physAdrT  busAdr,
  output logic [2:0]          busSize,
  output lsuBusPkg::busWordT  busWriteData,
  input  logic                busAck,
  input  lsuBusPkg::busWordT  busReadData,
  output logic [LogWpl-1:0]   wordCount
);

  // Line geometry is fixed here and handed down to the data path
  busDataPath #(
    .WordsPerLine(WordsPerLine),
    .LogWpl(LogWpl)
  ) u_busDataPath (
    .clk(clk),
    .reset(reset),
    .lsuReq(lsuReq),
    .ignoreRequest(ignoreRequest),
    .cpuBusy(cpuBusy),
    .busStall(busStall),
    .busCommitted(busCommitted),
    .cacheReq(cacheReq),
    .cacheLine(cacheLine),
    .cacheBusAck(cacheBusAck),
    .lineBuffer(lineBuffer),
    .selUncachedAdr(selUncachedAdr),
    .busRead(busRead),
    .busWrite(busWrite),
    .busAdr(busAdr),
    .busSize(busSize),
    .busWriteData(busWriteData),
    .busAck(busAck),
    .busReadData(busReadData),
    .wordCount(wordCount)
  );

endmodule

`default_nettype wire

//--- verilog/busDataPath.sv
`default_nettype none

module busDataPath #(
  parameter int WordsPerLine = 4,
  parameter int LogWpl = 2,
  localparam int LineLen = WordsPerLine * lsuBusPkg::XLEN
) (
  input  logic                clk,
  input  logic                reset,
  // Pipeline side
  input  lsuBusPkg::lsuReqT   lsuReq,
  input  logic                ignoreRequest,
  input  logic                cpuBusy,
  output logic                busStall,
  output logic                busCommitted,
  // Cache side
  input  lsuBusPkg::cacheReqT cacheReq,
  input  logic [LineLen-1:0]  cacheLine,
  output logic                cacheBusAck,
  output logic [LineLen-1:0]  lineBuffer,
  output logic                selUncachedAdr,
  // Memory bus side
  output logic                busRead,
  output logic                busWrite,
  output lsuBusPkg::physAdrT  busAdr,
  output logic [2:0]          busSize,
  output lsuBusPkg::busWordT  busWriteData,
  input  logic                busAck,
  input  lsuBusPkg::busWordT  busReadData,
  output logic [LogWpl-1:0]   wordCount
);
  import lsuBusPkg::*;

  physAdrT localAdr;
  physAdrT wordOffset;
  busWordT lineWord;
  logic    selLineWord;

  //////////////////////////////
  // Address and size
  //////////////////////////////

  // Pipeline address for uncached accesses, line base address otherwise
  assign localAdr = selUncachedAdr ? lsuReq.adr : cacheReq.lineAdr;

  // Byte offset of the current word inside the line
  // Stays zero for uncached accesses since the count only moves on line traffic
  assign wordOffset = physAdrT'(wordCount) << ByteOffset;
  assign busAdr = localAdr + wordOffset;

  // Uncached accesses keep the size of the instruction
  assign busSize = selUncachedAdr ? lsuReq.funct3 : WordSize;

  //////////////////////////////
  // Write data
  //////////////////////////////

  // Word of the victim line that goes out next
  assign lineWord = cacheLine[wordCount*XLEN +: XLEN];

  assign busWriteData = selLineWord ? lineWord : lsuReq.writeData;

  //////////////////////////////
  // Fill buffer
  //////////////////////////////

  // Read data is valid in its acknowledge cycle and lands in the word the
  // count points at, the count moves on at the same edge
  always_ff @(posedge clk) begin
    if (busAck && busRead) begin
      lineBuffer[wordCount*XLEN +: XLEN] <= busReadData;
    end
  end

  // Sequencer for all bus transfers
  busFsm #(
    .WordsPerLine(WordsPerLine),
    .LogWpl(LogWpl)
  ) u_busFsm (
    .clk(clk),
    .reset(reset),
    .lsuRw(lsuReq.rw),
    .cacheable(lsuReq.cacheable),
    .ignoreRequest(ignoreRequest),
    .cpuBusy(cpuBusy),
    .fetchLine(cacheReq.fetchLine),
    .writeLine(cacheReq.writeLine),
    .busAck(busAck),
    .busRead(busRead),
    .busWrite(busWrite),
    .busStall(busStall),
    .busCommitted(busCommitted),
    .cacheBusAck(cacheBusAck),
    .selUncachedAdr(selUncachedAdr),
    .selLineWord(selLineWord),
    .wordCount(wordCount)
  );

endmodule

`default_nettype wire

//--- verilog/busFsm.sv
`default_nettype none

module busFsm #(
  parameter int WordsPerLine = 4,
  parameter int LogWpl = 2
) (
  input  logic              clk,
  input  logic              reset,
  // Pipeline request fields
  input  logic [1:0]        lsuRw,
  input  logic              cacheable,
  input  logic              ignoreRequest,
  input  logic              cpuBusy,
  // Line requests from the data cache
  input  logic              fetchLine,
  input  logic              writeLine,
  // Memory bus handshake
  input  logic              busAck,
  output logic              busRead,
  output logic              busWrite,
  // Status back to the pipeline and the cache
  output logic              busStall,
  output logic              busCommitted,
  output logic              cacheBusAck,
  output logic              selUncachedAdr,
  output logic              selLineWord,
  output logic [LogWpl-1:0] wordCount
);
  import lsuBusPkg::*;

  // Count value of the final word of a line
  localparam logic [LogWpl-1:0] LastWord = LogWpl'(WordsPerLine - 1);

  busStateT state;
  busStateT nextState;

  // Kind of transfer being driven onto the bus in this cycle
  logic uncachedRead;
  logic uncachedWrite;
  logic lineFetch;
  logic lineWrite;
  logic uncachedXfer;
  logic lineXfer;
  logic lastAck;

  //////////////////////////////
  // Transfer decode
  //////////////////////////////

  // In stReady the transfer is picked straight from the requests, so the strobe
  // rises in the same cycle the request shows up
  always_comb begin
    uncachedRead = 1'b0;
    uncachedWrite = 1'b0;
    lineFetch = 1'b0;
    lineWrite = 1'b0;
    case (state)
      stReady: begin
        if (!ignoreRequest) begin
          // Uncached pipeline access wins over any line traffic
          if ((|lsuRw) && !cacheable) begin
            uncachedRead = lsuRw[1];
            uncachedWrite = ~lsuRw[1] & lsuRw[0];
          end else if (writeLine) begin
            // Dirty victim goes out before the new line comes in
            lineWrite = 1'b1;
          end else if (fetchLine) begin
            lineFetch = 1'b1;
          end
        end
      end
      stUncachedRead: uncachedRead = 1'b1;
      stUncachedWrite: uncachedWrite = 1'b1;
      stLineFetch: lineFetch = 1'b1;
      stLineWrite: lineWrite = 1'b1;
      default: begin
        // stCpuBusyHold keeps the bus idle
      end
    endcase
  end

  assign uncachedXfer = uncachedRead | uncachedWrite;
  assign lineXfer = lineFetch | lineWrite;

  // The acknowledge of the last word finishes a line
  assign lastAck = lineXfer & busAck & (wordCount == LastWord);

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      stReady: begin
        if (uncachedXfer) begin
          // A zero wait state acknowledge completes the access right here
          if (!busAck) begin
            nextState = uncachedRead ? stUncachedRead : stUncachedWrite;
          end else if (cpuBusy) begin
            nextState = stCpuBusyHold;
          end
        end else if (lineWrite && !lastAck) begin
          nextState = stLineWrite;
        end else if (lineFetch && !lastAck) begin
          nextState = stLineFetch;
        end
      end
      stUncachedRead, stUncachedWrite: begin
        // Park while the pipeline is busy so the access is not issued twice
        if (busAck) begin
          nextState = cpuBusy ? stCpuBusyHold : stReady;
        end
      end
      stCpuBusyHold: begin
        if (!cpuBusy) begin
          nextState = stReady;
        end
      end
      stLineFetch, stLineWrite: begin
        if (lastAck) begin
          nextState = stReady;
        end
      end
      default: nextState = stReady;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stReady;
    end else begin
      state <= nextState;
    end
  end

  // Word count walks through the line, wrapping to zero after the last word
  always_ff @(posedge clk) begin
    if (reset) begin
      wordCount <= '0;
    end else if (lineXfer && busAck) begin
      wordCount <= lastAck ? '0 : wordCount + 1'b1;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign busRead = uncachedRead | lineFetch;
  assign busWrite = uncachedWrite | lineWrite;

  // Only uncached accesses hold the pipeline, line traffic is stalled by the cache
  assign busStall = uncachedXfer;
  assign busCommitted = (state != stReady);
  assign cacheBusAck = lastAck;

  // Bus address and size come from the pipeline during uncached accesses
  assign selUncachedAdr = uncachedXfer;
  assign selLineWord = lineWrite;   // write data from the victim line

endmodule

`default_nettype wire

//--- verilog/lsuBusPkg.sv
`default_nettype none

package lsuBusPkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Data bus and physical address widths of the core
  localparam int XLEN = 32;
  localparam int PA_BITS = 32;

  // Number of low address bits that select a byte inside a bus word
  localparam int ByteOffset = $clog2(XLEN / 8);

  // A full-word transfer in funct3 size encoding
  localparam logic [2:0] WordSize = 3'(ByteOffset);

  // One word as it travels on the memory bus
  typedef logic [XLEN-1:0] busWordT;

  // A byte address in physical memory
  typedef logic [PA_BITS-1:0] physAdrT;

  //////////////////////////////
  // Requests
  //////////////////////////////

  // Request from the load/store stage
  // In rw, bit 1 asks for a read and bit 0 for a write
  typedef struct packed {
    physAdrT    adr;
    logic [1:0] rw;
    logic [2:0] funct3;
    logic       cacheable;
    busWordT    writeData;
  } lsuReqT;

  // Line request from the data cache, both strobes are levels
  typedef struct packed {
    physAdrT lineAdr;
    logic    fetchLine;
    logic    writeLine;
  } cacheReqT;

  // States of the bus sequencer
  typedef enum logic [2:0] {
    stReady,
    stUncachedRead,
    stUncachedWrite,
    stCpuBusyHold,
    stLineFetch,
    stLineWrite
  } busStateT;

endpackage

`default_nettype wire
